// ==== source/clic_pkg.sv ====
// shared CLIC types; vector and entry CSR windows hold at most 64 lines each
`default_nettype none

package clic_pkg;

  // csr data and address
  typedef logic [31:0] word;
  typedef logic [11:0] csr_addr_t;

  // instruction memory side
  localparam int IMemAddrWidth = 32;
  typedef logic [IMemAddrWidth-1:0] imem_addr_t;

  // priority levels, 0 is the lowest
  localparam int PrioWidth = 4;
  typedef logic [PrioWidth-1:0] prio_t;

  // mstatus holds only the low bits, global enable at bit 3
  localparam int MStatusWidth = 4;
  localparam int MStatusMieBit = 3;

  // csr operation as decoded by the core
  typedef enum logic [1:0] {
    CSR_NONE  = 2'b00,
    CSR_WRITE = 2'b01,
    CSR_SET   = 2'b10,
    CSR_CLEAR = 2'b11
  } csr_op_e;

  // entry layout keeps pend in bit 0 so a 5 bit immediate reaches all fields
  typedef struct packed {
    prio_t prio;
    logic  enabled;
    logic  pended;
  } entry_t;

  // one level of the return stack
  typedef struct packed {
    imem_addr_t addr;
    prio_t      thresh;
  } stack_entry_t;

  // pc mux select towards the core
  typedef enum logic {
    PC_NORMAL    = 1'b0,
    PC_INTERRUPT = 1'b1
  } pc_sel_e;

  // fixed csr map
  localparam csr_addr_t MStatusAddr      = 12'h300;
  localparam csr_addr_t MIntThreshAddr   = 12'h347;
  localparam csr_addr_t StackDepthAddr   = 12'h350;
  localparam csr_addr_t TimerCompareAddr = 12'h400;

  // per line windows, line k sits at base + k
  localparam csr_addr_t VecCsrBase   = 12'hb00;
  localparam csr_addr_t EntryCsrBase = 12'hb40;

endpackage : clic_pkg

`default_nettype wire

// ==== source/csr_reg.sv ====
// one CSR; a software access in the same cycle wins over the external write
`default_nettype none

module csr_reg #(
  parameter int                  CsrWidth = 32,
  parameter clic_pkg::csr_addr_t Addr     = '0
) (
  input  wire                  clk,
  input  wire                  rst_i,

  // shared csr bus
  input  wire                  csr_enable_i,
  input  clic_pkg::csr_addr_t  csr_addr_i,
  input  clic_pkg::csr_op_e    csr_op_i,
  input  clic_pkg::word        csr_data_i,

  // hardware side update
  input  wire                  ext_we_i,
  input  wire [CsrWidth-1:0]   ext_data_i,

  output logic [CsrWidth-1:0]  value_o,
  output clic_pkg::word        rdata_o
);
  import clic_pkg::*;

  logic [CsrWidth-1:0] data_q;
  logic [CsrWidth-1:0] src;
  logic                sw_access;

  assign sw_access = csr_enable_i && (csr_addr_i == Addr) && (csr_op_i != CSR_NONE);
  // upper bus bits beyond the register are dropped
  assign src = csr_data_i[CsrWidth-1:0];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      data_q <= '0;
    end else if (sw_access) begin
      case (csr_op_i)
        CSR_WRITE: data_q <= src;
        CSR_SET:   data_q <= data_q | src;
        CSR_CLEAR: data_q <= data_q & ~src;
        default:   data_q <= data_q;
      endcase
    end else if (ext_we_i) begin
      data_q <= ext_data_i;
    end
  end

  assign value_o = data_q;
  assign rdata_o = word'(data_q);

endmodule : csr_reg

`default_nettype wire

// ==== source/clic_timer.sv ====
// free-running compare timer; a compare value of zero stops the pend pulses
`default_nettype none

module clic_timer (
  input  wire                 clk,
  input  wire                 rst_i,

  // shared csr bus
  input  wire                 csr_enable_i,
  input  clic_pkg::csr_addr_t csr_addr_i,
  input  clic_pkg::csr_op_e   csr_op_i,
  input  clic_pkg::word       csr_data_i,

  output clic_pkg::word       rdata_o,
  output logic                pend_o
);
  import clic_pkg::*;

  word  compare;
  word  count_q;
  logic wrap;

  // compare value, software access only
  csr_reg #(
    .CsrWidth ($bits(word)),
    .Addr     (TimerCompareAddr)
  ) compare_csr (
    .clk,
    .rst_i,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .csr_data_i,
    .ext_we_i   (1'b0),
    .ext_data_i ('0),
    .value_o    (compare),
    .rdata_o
  );

  // also recovers when compare is lowered below the running count
  assign wrap = (count_q >= compare);

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count_q <= '0;
    end else if (wrap) begin
      count_q <= '0;
    end else begin
      count_q <= count_q + 32'd1;
    end
  end

  // one pulse per period of compare + 1 cycles
  assign pend_o = wrap && (compare != '0);

endmodule : clic_timer

`default_nettype wire

// ==== source/epc_stack.sv ====
// return stack of StackDepth-1 levels; push when full and pop when empty are ignored
`default_nettype none

module epc_stack #(
  parameter int StackDepth = 16
) (
  input  wire                    clk,
  input  wire                    rst_i,

  input  wire                    push_i,
  input  wire                    pop_i,
  input  clic_pkg::stack_entry_t data_i,

  output clic_pkg::stack_entry_t data_o,
  output clic_pkg::prio_t        depth_o
);
  import clic_pkg::*;

  // each nesting level raises the threshold, so StackDepth-1 levels are enough
  localparam prio_t IdxMax = prio_t'(StackDepth - 1);

  stack_entry_t mem [StackDepth-1];
  prio_t        idx_q;
  prio_t        top_idx;

  always_ff @(posedge clk) begin
    if (push_i && (idx_q != IdxMax)) begin
      mem[idx_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      idx_q <= '0;
    end else if (push_i) begin
      if (idx_q != IdxMax) idx_q <= idx_q + 1'b1;
    end else if (pop_i && (idx_q != '0)) begin
      idx_q <= idx_q - 1'b1;
    end
  end

  // top entry, slot 0 when empty
  assign top_idx = (idx_q == '0) ? '0 : idx_q - 1'b1;
  assign data_o  = mem[top_idx];
  assign depth_o = idx_q;

endmodule : epc_stack

`default_nettype wire

// ==== source/prio_arbiter.sv ====
// combinational max search over VecSize >= 2 lines; on equal priority the higher index wins
`default_nettype none

module prio_arbiter #(
  parameter int VecSize = 8
) (
  input  clic_pkg::entry_t     entries_i [VecSize],
  input  clic_pkg::imem_addr_t vectors_i [VecSize],
  input  clic_pkg::prio_t      thresh_i,

  output clic_pkg::prio_t      max_prio_o,
  output logic [$clog2(VecSize)-1:0] max_id_o,
  output clic_pkg::imem_addr_t max_vec_o,
  output logic                 found_o
);
  import clic_pkg::*;

  localparam int IdWidth = $clog2(VecSize);

  // running maximum starts at the threshold
  always_comb begin
    max_prio_o = thresh_i;
    max_id_o   = '0;
    max_vec_o  = '0;
    found_o    = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      // >= lets a later line take over on a tie
      if (entries_i[k].enabled && entries_i[k].pended &&
          (entries_i[k].prio >= max_prio_o)) begin
        max_prio_o = entries_i[k].prio;
        max_id_o   = IdWidth'(k);
        max_vec_o  = vectors_i[k];
        found_o    = 1'b1;
      end
    end
  end

endmodule : prio_arbiter

`default_nettype wire

// ==== source/n_clic.sv ====
// nested CLIC top; pc_i of all ones marks an interrupt return, the core follows pc_sel_o at once
`default_nettype none

module n_clic #(
  parameter int VecSize = 8
) (
  input  wire                  clk,
  input  wire                  rst_i,

  // csr bus from the core
  input  wire                  csr_enable_i,
  input  clic_pkg::csr_addr_t  csr_addr_i,
  input  clic_pkg::csr_op_e    csr_op_i,
  input  clic_pkg::word        csr_data_i,

  // current pc, all ones on return
  input  clic_pkg::imem_addr_t pc_i,

  output clic_pkg::word        csr_data_o,
  output clic_pkg::imem_addr_t int_addr_o,
  output logic [$clog2(VecSize)-1:0] int_id_o,
  output clic_pkg::prio_t      int_prio_o,
  output clic_pkg::pc_sel_e    pc_sel_o,
  output clic_pkg::prio_t      level_o,
  output logic                 interrupt_o,
  output logic                 tail_chain_o
);
  import clic_pkg::*;

  localparam int StackDepth = 2 ** PrioWidth;

  // mstatus
  logic [MStatusWidth-1:0] mstatus_q;
  word                     mstatus_rdata;

  csr_reg #(
    .CsrWidth (MStatusWidth),
    .Addr     (MStatusAddr)
  ) mstatus_csr (
    .clk,
    .rst_i,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .csr_data_i,
    .ext_we_i   (1'b0),
    .ext_data_i ('0),
    .value_o    (mstatus_q),
    .rdata_o    (mstatus_rdata)
  );

  // threshold, also written by take, tail-chain and return
  prio_t thresh_q;
  prio_t thresh_wdata;
  logic  thresh_we;
  word   thresh_rdata;

  csr_reg #(
    .CsrWidth (PrioWidth),
    .Addr     (MIntThreshAddr)
  ) thresh_csr (
    .clk,
    .rst_i,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .csr_data_i,
    .ext_we_i   (thresh_we),
    .ext_data_i (thresh_wdata),
    .value_o    (thresh_q),
    .rdata_o    (thresh_rdata)
  );

  // vector table and entries
  imem_addr_t vec_q       [VecSize];
  word        vec_rdata   [VecSize];
  entry_t     entry_q     [VecSize];
  word        entry_rdata [VecSize];
  logic       entry_we    [VecSize];
  entry_t     entry_wdata [VecSize];

  for (genvar k = 0; k < VecSize; k++) begin : gen_line
    csr_reg #(
      .CsrWidth (IMemAddrWidth),
      .Addr     (VecCsrBase + csr_addr_t'(k))
    ) vec_csr (
      .clk,
      .rst_i,
      .csr_enable_i,
      .csr_addr_i,
      .csr_op_i,
      .csr_data_i,
      .ext_we_i   (1'b0),
      .ext_data_i ('0),
      .value_o    (vec_q[k]),
      .rdata_o    (vec_rdata[k])
    );

    csr_reg #(
      .CsrWidth ($bits(entry_t)),
      .Addr     (EntryCsrBase + csr_addr_t'(k))
    ) entry_csr (
      .clk,
      .rst_i,
      .csr_enable_i,
      .csr_addr_i,
      .csr_op_i,
      .csr_data_i,
      .ext_we_i   (entry_we[k]),
      .ext_data_i (entry_wdata[k]),
      .value_o    (entry_q[k]),
      .rdata_o    (entry_rdata[k])
    );
  end

  // compare timer pends line 0
  word  timer_rdata;
  logic timer_pend;

  clic_timer timer (
    .clk,
    .rst_i,
    .csr_enable_i,
    .csr_addr_i,
    .csr_op_i,
    .csr_data_i,
    .rdata_o (timer_rdata),
    .pend_o  (timer_pend)
  );

  // return stack
  logic         push;
  logic         pop;
  stack_entry_t push_data;
  stack_entry_t stack_top;

  assign push_data = '{addr: pc_i, thresh: thresh_q};

  epc_stack #(
    .StackDepth (StackDepth)
  ) stack (
    .clk,
    .rst_i,
    .push_i  (push),
    .pop_i   (pop),
    .data_i  (push_data),
    .data_o  (stack_top),
    .depth_o (level_o)
  );

  // highest pending line
  prio_t                      max_prio;
  logic [$clog2(VecSize)-1:0] max_id;
  imem_addr_t                 max_vec;
  logic                       found;

  prio_arbiter #(
    .VecSize (VecSize)
  ) arbiter (
    .entries_i  (entry_q),
    .vectors_i  (vec_q),
    .thresh_i   (thresh_q),
    .max_prio_o (max_prio),
    .max_id_o   (max_id),
    .max_vec_o  (max_vec),
    .found_o    (found)
  );

  logic ret_pc;
  logic take;

  assign ret_pc = (pc_i == '1);
  assign take   = mstatus_q[MStatusMieBit] && found && (max_prio > thresh_q);

  // take, tail-chain, return or none
  always_comb begin
    push         = 1'b0;
    pop          = 1'b0;
    thresh_we    = 1'b0;
    thresh_wdata = thresh_q;
    interrupt_o  = 1'b0;
    tail_chain_o = 1'b0;
    pc_sel_o     = PC_NORMAL;
    int_addr_o   = pc_i;
    int_id_o     = '0;
    int_prio_o   = thresh_q;
    for (int k = 0; k < VecSize; k++) begin
      entry_we[k]    = 1'b0;
      entry_wdata[k] = entry_q[k];
    end

    if (timer_pend) begin
      entry_we[0]           = 1'b1;
      entry_wdata[0].pended = 1'b1;
    end

    // on a return pc a waiting line is chained instead of pushing the all ones pc
    if (ret_pc && found) begin
      tail_chain_o = 1'b1;
      interrupt_o  = 1'b1;
      pc_sel_o     = PC_INTERRUPT;
      int_addr_o   = max_vec;
      int_id_o     = max_id;
      int_prio_o   = max_prio;
      thresh_we    = 1'b1;
      thresh_wdata = max_prio;
    end else if (take) begin
      push         = 1'b1;
      interrupt_o  = 1'b1;
      pc_sel_o     = PC_INTERRUPT;
      int_addr_o   = max_vec;
      int_id_o     = max_id;
      int_prio_o   = max_prio;
      thresh_we    = 1'b1;
      thresh_wdata = max_prio;
    end else if (ret_pc) begin
      pop          = 1'b1;
      pc_sel_o     = PC_INTERRUPT;
      int_addr_o   = stack_top.addr;
      int_prio_o   = stack_top.thresh;
      thresh_we    = 1'b1;
      thresh_wdata = stack_top.thresh;
    end

    // clearing the served line overrides a timer pend in the same cycle
    if (tail_chain_o || push) begin
      entry_we[max_id]           = 1'b1;
      entry_wdata[max_id].pended = 1'b0;
    end
  end

  // csr read mux
  always_comb begin
    csr_data_o = '0;
    if (csr_addr_i == MStatusAddr) begin
      csr_data_o = mstatus_rdata;
    end else if (csr_addr_i == MIntThreshAddr) begin
      csr_data_o = thresh_rdata;
    end else if (csr_addr_i == TimerCompareAddr) begin
      csr_data_o = timer_rdata;
    end else if (csr_addr_i == StackDepthAddr) begin
      csr_data_o = word'(level_o);
    end else begin
      for (int k = 0; k < VecSize; k++) begin
        if (csr_addr_i == VecCsrBase + csr_addr_t'(k)) csr_data_o = vec_rdata[k];
        if (csr_addr_i == EntryCsrBase + csr_addr_t'(k)) csr_data_o = entry_rdata[k];
      end
    end
  end

endmodule : n_clic

`default_nettype wire

// ==== tests/tb_clk_gen.sv ====
// testbench clock of period 2*HalfPeriod ns; reset is released on a rising edge
`default_nettype none

module tb_clk_gen #(
  parameter int HalfPeriod  = 2,
  parameter int ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule : tb_clk_gen

`default_nettype wire

// ==== tests/n_clic_tb.sv ====
// testbench for n_clic with a cycle model checked 1 ns after each falling edge
`default_nettype none

module n_clic_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import clic_pkg::*;

  localparam int  VecSize    = 8;
  localparam int  Rounds     = 12;
  localparam word NormalPc   = 32'h0000_1000;
  // each csr access takes two cycles, a round has about 4*VecSize accesses
  localparam int  CycleLimit = 2 * (Rounds * (8 * VecSize + 20) + 400);

  logic clk;
  logic rst_i;
  logic csr_enable_i;
  csr_addr_t csr_addr_i;
  csr_op_e csr_op_i;
  word csr_data_i;
  imem_addr_t pc_i;
  word csr_data_o;
  imem_addr_t int_addr_o;
  logic [2:0] int_id_o;
  prio_t int_prio_o;
  pc_sel_e pc_sel_o;
  prio_t level_o;
  logic interrupt_o;
  logic tail_chain_o;

  // model state, always the state after the next rising edge
  logic [3:0] mstat_m;
  prio_t thresh_m;
  word cmp_m;
  word cnt_m;
  imem_addr_t vec_m [VecSize];
  entry_t ent_m [VecSize];
  stack_entry_t stack_m [$];

  word lfsr_q;
  int errors;
  int test_no;
  int test_start;
  int failed_tests;
  int cycles;

  tb_clk_gen #(.HalfPeriod(2), .ResetCycles(2)) clk_gen (.clk_o(clk), .rst_o(rst_i));

  n_clic #(.VecSize(VecSize)) n_clic_i (
    .clk, .rst_i, .csr_enable_i, .csr_addr_i, .csr_op_i, .csr_data_i, .pc_i,
    .csr_data_o, .int_addr_o, .int_id_o, .int_prio_o, .pc_sel_o, .level_o,
    .interrupt_o, .tail_chain_o
  );

  // galois lfsr, one step per bit taken
  function automatic word rand_bits(input int n);
    word v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic word apply_op(input word old, input csr_op_e op, input word d,
                                   input word mask);
    word v;
    v = old;
    case (op)
      CSR_WRITE: v = d & mask;
      CSR_SET:   v = old | (d & mask);
      CSR_CLEAR: v = old & ~(d & mask);
      default:   v = old;
    endcase
    return v;
  endfunction

  function automatic word model_read(input csr_addr_t a);
    word v;
    v = '0;
    if (a == MStatusAddr) v = word'(mstat_m);
    else if (a == MIntThreshAddr) v = word'(thresh_m);
    else if (a == TimerCompareAddr) v = cmp_m;
    else if (a == StackDepthAddr) v = word'(stack_m.size());
    for (int k = 0; k < VecSize; k++) begin
      if (a == VecCsrBase + csr_addr_t'(k)) v = vec_m[k];
      if (a == EntryCsrBase + csr_addr_t'(k)) v = word'(ent_m[k]);
    end
    return v;
  endfunction

  task automatic check(input string name, input word got, input word exp);
    assert (got === exp) else begin
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic reset_model();
    mstat_m = '0;
    thresh_m = '0;
    cmp_m = '0;
    cnt_m = '0;
    stack_m.delete();
    for (int k = 0; k < VecSize; k++) begin
      vec_m[k] = '0;
      ent_m[k] = '0;
    end
  endtask

  // compare outputs with the model, then advance it by one clock
  task automatic check_and_step();
    prio_t mx;
    int id;
    word vec;
    logic fnd, ret, tl, tk, rt, sw, tp;
    stack_entry_t top;
    mx = thresh_m;
    id = 0;
    vec = '0;
    fnd = 1'b0;
    for (int k = 0; k < VecSize; k++) begin
      if (ent_m[k].enabled && ent_m[k].pended && ent_m[k].prio >= mx) begin
        mx = ent_m[k].prio;
        id = k;
        vec = vec_m[k];
        fnd = 1'b1;
      end
    end
    ret = (pc_i == '1);
    tl = ret && fnd;
    tk = !tl && mstat_m[MStatusMieBit] && fnd && (mx > thresh_m);
    rt = !tl && !tk && ret;
    top = (stack_m.size() > 0) ? stack_m[$] : '0;
    check("interrupt_o", word'(interrupt_o), word'(tl || tk));
    check("tail_chain_o", word'(tail_chain_o), word'(tl));
    check("pc_sel_o", word'(pc_sel_o), word'(tl || tk || rt));
    if (tl || tk) begin
      check("int_addr_o", int_addr_o, vec);
      check("int_id_o", word'(int_id_o), word'(id));
      check("int_prio_o", word'(int_prio_o), word'(mx));
    end else if (rt) begin
      if (stack_m.size() > 0) check("int_addr_o", int_addr_o, top.addr);
    end else begin
      check("int_addr_o", int_addr_o, pc_i);
    end
    check("level_o", word'(level_o), word'(stack_m.size()));
    check("csr_data_o", csr_data_o, model_read(csr_addr_i));

    sw = csr_enable_i && (csr_op_i != CSR_NONE);
    tp = (cnt_m == cmp_m) && (cmp_m != '0);
    cnt_m = (cnt_m == cmp_m) ? '0 : cnt_m + 32'd1;
    if (tk && stack_m.size() < 15) begin
      stack_m.push_back(stack_entry_t'{addr: pc_i, thresh: thresh_m});
    end
    if (rt && stack_m.size() > 0) void'(stack_m.pop_back());
    if (sw && csr_addr_i == MIntThreshAddr) begin
      thresh_m = prio_t'(apply_op(word'(thresh_m), csr_op_i, csr_data_i, 32'hf));
    end else if (tl || tk) begin
      thresh_m = mx;
    end else if (rt && top != '0) begin
      thresh_m = top.thresh;
    end
    for (int k = 0; k < VecSize; k++) begin
      if (sw && csr_addr_i == EntryCsrBase + csr_addr_t'(k)) begin
        ent_m[k] = entry_t'(6'(apply_op(word'(ent_m[k]), csr_op_i, csr_data_i, 32'h3f)));
      end else if ((tl || tk) && id == k) begin
        ent_m[k].pended = 1'b0;
      end else if (k == 0 && tp) begin
        ent_m[k].pended = 1'b1;
      end
      if (sw && csr_addr_i == VecCsrBase + csr_addr_t'(k)) begin
        vec_m[k] = apply_op(vec_m[k], csr_op_i, csr_data_i, '1);
      end
    end
    if (sw && csr_addr_i == MStatusAddr) begin
      mstat_m = 4'(apply_op(word'(mstat_m), csr_op_i, csr_data_i, 32'hf));
    end
    if (sw && csr_addr_i == TimerCompareAddr) cmp_m = apply_op(cmp_m, csr_op_i, csr_data_i, '1);
  endtask

  always @(negedge clk) begin
    #1;
    if (rst_i) reset_model();
    else check_and_step();
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("run stopped after %0d cycles without finishing", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // the address stays on the bus so the next cycle reads the register back
  task automatic csr_access(input csr_addr_t addr, input csr_op_e op, input word data);
    @(negedge clk);
    csr_enable_i = 1'b1;
    csr_addr_i = addr;
    csr_op_i = op;
    csr_data_i = data;
    @(negedge clk);
    csr_enable_i = 1'b0;
    csr_op_i = CSR_NONE;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic clear_lines();
    for (int k = 0; k < VecSize; k++) csr_access(EntryCsrBase + csr_addr_t'(k), CSR_WRITE, '0);
  endtask

  // pops until the stack is empty, starting on the next falling edge
  task automatic unwind();
    @(negedge clk);
    while (level_o != '0) begin
      pc_i = '1;
      @(negedge clk);
    end
    pc_i = NormalPc;
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d errors", test_no, name, errors - test_start);
    if (errors != test_start) failed_tests++;
    test_no++;
    test_start = errors;
  endtask

  task automatic test_csr_access();
    for (int i = 0; i < 6; i++) csr_access(MStatusAddr, csr_op_e'(rand_bits(2)), rand_bits(4));
    csr_access(MStatusAddr, CSR_CLEAR, 32'hf);
    for (int i = 0; i < 6; i++) csr_access(MIntThreshAddr, csr_op_e'(rand_bits(2)), rand_bits(8));
    for (int k = 0; k < VecSize; k++) begin
      csr_access(VecCsrBase + csr_addr_t'(k), CSR_WRITE, rand_bits(32));
      csr_access(VecCsrBase + csr_addr_t'(k), csr_op_e'(rand_bits(2)), rand_bits(32));
      csr_access(EntryCsrBase + csr_addr_t'(k), csr_op_e'(rand_bits(2)), rand_bits(8));
    end
    csr_access(StackDepthAddr, CSR_NONE, '0);
    clear_lines();
    csr_access(MIntThreshAddr, CSR_WRITE, '0);
    end_test("csr access");
  endtask

  task automatic test_priority();
    word p;
    for (int r = 0; r < Rounds; r++) begin
      csr_access(MIntThreshAddr, CSR_WRITE, rand_bits(2));
      for (int k = 0; k < VecSize; k++) begin
        // first round forces all lines to one priority
        p = (r == 0) ? 32'd9 : rand_bits(4);
        csr_access(VecCsrBase + csr_addr_t'(k), CSR_WRITE, rand_bits(32));
        csr_access(EntryCsrBase + csr_addr_t'(k), CSR_WRITE,
                   word'({p[3:0], 2'(rand_bits(2))}));
      end
      csr_access(MStatusAddr, CSR_SET, 32'h8);
      for (int k = 0; k < VecSize; k++) begin
        csr_addr_i = EntryCsrBase + csr_addr_t'(k);
        idle(1);
      end
      csr_access(MStatusAddr, CSR_CLEAR, 32'h8);
      clear_lines();
      unwind();
    end
    csr_access(MIntThreshAddr, CSR_WRITE, '0);
    end_test("priority take");
  endtask

  task automatic test_masked();
    for (int k = 0; k < VecSize; k++) begin
      csr_access(EntryCsrBase + csr_addr_t'(k), CSR_WRITE,
                 word'({3'(rand_bits(3)), 1'b1, 2'b11}));
    end
    repeat (4) begin
      @(negedge clk);
      #1;
      check("interrupt_o", word'(interrupt_o), 32'd0);
      check("int_addr_o", int_addr_o, pc_i);
    end
    clear_lines();
    end_test("global enable clear");
  endtask

  task automatic test_nesting();
    csr_access(VecCsrBase + csr_addr_t'(1), CSR_WRITE, 32'h0000_2000);
    csr_access(VecCsrBase + csr_addr_t'(2), CSR_WRITE, 32'h0000_3000);
    csr_access(EntryCsrBase + csr_addr_t'(1), CSR_WRITE, word'({4'd3, 2'b11}));
    csr_access(MStatusAddr, CSR_SET, 32'h8);
    idle(1);
    pc_i = 32'h0000_2010;
    csr_access(EntryCsrBase + csr_addr_t'(2), CSR_WRITE, word'({4'd7, 2'b11}));
    idle(1);
    pc_i = 32'h0000_3010;
    csr_addr_i = MIntThreshAddr;
    #1;
    check("level_o", word'(level_o), 32'd2);
    idle(1);
    pc_i = '1;
    idle(1);
    pc_i = 32'h0000_2010;
    #1;
    check("level_o", word'(level_o), 32'd1);
    unwind();
    csr_access(MStatusAddr, CSR_CLEAR, 32'h8);
    clear_lines();
    end_test("nesting and return");
  endtask

  task automatic test_tail_chain();
    csr_access(EntryCsrBase + csr_addr_t'(1), CSR_WRITE, word'({4'd3, 2'b11}));
    csr_access(MStatusAddr, CSR_SET, 32'h8);
    idle(1);
    pc_i = 32'h0000_2010;
    csr_access(EntryCsrBase + csr_addr_t'(2), CSR_WRITE, word'({4'd3, 2'b11}));
    pc_i = '1;
    #1;
    check("tail_chain_o", word'(tail_chain_o), 32'd1);
    check("level_o", word'(level_o), 32'd1);
    check("int_addr_o", int_addr_o, 32'h0000_3000);
    idle(1);
    unwind();
    csr_access(MStatusAddr, CSR_CLEAR, 32'h8);
    clear_lines();
    end_test("tail chain");
  endtask

  task automatic test_timer();
    word cmp;
    int n;
    cmp = 32'd3 + rand_bits(3);
    csr_access(TimerCompareAddr, CSR_WRITE, cmp);
    csr_addr_i = EntryCsrBase;
    n = 0;
    #1;
    while (csr_data_o[0] != 1'b1 && n <= int'(cmp) + 2) begin
      @(negedge clk);
      #1;
      n++;
    end
    assert (csr_data_o[0] == 1'b1) else begin
      $display("timer did not pend line 0 within %0d cycles", int'(cmp) + 2);
      errors++;
    end
    csr_access(TimerCompareAddr, CSR_WRITE, '0);
    clear_lines();
    end_test("compare timer");
  endtask

  initial begin
    csr_enable_i = 1'b0;
    csr_addr_i = '0;
    csr_op_i = CSR_NONE;
    csr_data_i = '0;
    pc_i = NormalPc;
    lfsr_q = 32'hf895_7523;
    errors = 0;
    test_no = 1;
    test_start = 0;
    failed_tests = 0;
    cycles = 0;
    reset_model();
    wait (rst_i == 1'b0);
    test_csr_access();
    test_priority();
    test_masked();
    test_nesting();
    test_tail_chain();
    test_timer();
    $display("tests %0d, failed tests %0d, errors %0d", test_no - 1, failed_tests, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : n_clic_tb

`default_nettype wire

// ==== sim.f ====
source/clic_pkg.sv
source/csr_reg.sv
source/clic_timer.sv
source/epc_stack.sv
source/prio_arbiter.sv
source/n_clic.sv
tests/tb_clk_gen.sv
tests/n_clic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the n_clic testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/100ps -f sim.f \
  --top-module n_clic_tb -o n_clic_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/n_clic_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' sim.log; then
  exit 1
fi
exit 0
